//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - include
    files:
      - verilog/icache_pkg.sv
      - verilog/icache_store.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_refill_axi.sv
      - verilog/icache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/axi_lite_mem_model.sv
      - tb/icache_tb.sv

//--- flist.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_store.sv
verilog/icache_ctrl.sv
verilog/icache_refill_axi.sv
verilog/icache_top.sv
tb/axi_lite_mem_model.sv
tb/icache_tb.sv

//--- include/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Fetch and AXI address width
`define ICACHE_ADDR_W 32

// Direct-mapped geometry
`define ICACHE_LINES 16
`define ICACHE_LINE_BYTES 16

// One AXI beat carries one instruction word
`define ICACHE_AXI_DW 32

`endif

//--- tb/axi_lite_mem_model.sv
module axi_lite_mem_model #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,

    input  icache_pkg::addr_t araddr,
    input  logic              arvalid,
    output logic              arready,
    output icache_pkg::word_t rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    word_t       mem      [MEM_WORDS];
    int unsigned ar_delay [LINE_WORDS] = '{default: 0};  // per word slot of a line
    int unsigned r_delay  [LINE_WORDS] = '{default: 0};
    int unsigned ar_cnt;
    int unsigned r_cnt;
    logic        busy;  // one read in flight
    addr_t       addr_q;

    assign rresp = 2'b00;

    function automatic int unsigned word_index(addr_t addr);
        return (addr >> BOFF_W) % MEM_WORDS;
    endfunction

    function automatic int unsigned word_slot(addr_t addr);
        return addr[BOFF_W +: WOFF_W];
    endfunction

    task automatic write_word(addr_t addr, word_t data);
        mem[word_index(addr)] = data;
    endtask

    task automatic set_delay(int unsigned slot, int unsigned ar_d, int unsigned r_d);
        ar_delay[slot] = ar_d;
        r_delay[slot]  = r_d;
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            busy    <= 1'b0;
            ar_cnt  <= 0;
            r_cnt   <= 0;
            addr_q  <= '0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                busy    <= 1'b1;
                addr_q  <= araddr;
                ar_cnt  <= 0;
                r_cnt   <= 0;
            end else if (arvalid) begin
                if (ar_cnt >= ar_delay[word_slot(araddr)]) arready <= 1'b1;
                else ar_cnt <= ar_cnt + 1;
            end
        end else if (!rvalid) begin
            if (r_cnt >= r_delay[word_slot(addr_q)]) begin
                rvalid <= 1'b1;
                rdata  <= mem[word_index(addr_q)];
            end else begin
                r_cnt <= r_cnt + 1;
            end
        end else if (rready) begin
            rvalid <= 1'b0;  // beat taken
            busy   <= 1'b0;
        end
    end

endmodule

//--- tb/icache_tb.sv
`include "icache_defines.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    localparam int unsigned MEM_WORDS      = 256;  // 64 lines
    localparam int unsigned RAND_FETCHES   = 200;
    localparam int unsigned TOTAL_FETCHES  = 1 + 4 + 6 + 2 + 2 + RAND_FETCHES;
    localparam int unsigned TIMEOUT_CYCLES = 200 * TOTAL_FETCHES;

    logic       clk;
    logic       rst;
    logic       fetch_valid;
    addr_t      fetch_addr;
    logic       fetch_ready;
    logic       resp_valid;
    word_t      resp_data;
    logic       fence_i;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    word_t       shadow [MEM_WORDS];  // expected memory contents
    addr_t       ar_addrs [$];
    int unsigned ar_count    = 0;
    int unsigned cycle_count = 0;

    icache_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .fence_i     (fence_i),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    axi_lite_mem_model #(.MEM_WORDS(MEM_WORDS)) mem_i (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Inputs only move on rising edges, so the falling edge sees the coming handshake
    always @(negedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_count++;
            ar_addrs.push_back(araddr);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int unsigned got, int unsigned exp);
        if (got != exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic write_mem(addr_t addr, word_t data);
        shadow[(addr >> 2) % MEM_WORDS] = data;
        mem_i.write_word(addr, data);
    endtask

    function automatic word_t expected_word(addr_t addr);
        return shadow[(addr >> 2) % MEM_WORDS];
    endfunction

    task automatic shuffle_latency();
        for (int unsigned i = 0; i < LINE_WORDS; i++) begin
            mem_i.set_delay(i, $urandom_range(3, 0), $urandom_range(3, 0));
        end
    endtask

    // lat counts cycles from acceptance to resp_valid
    task automatic do_fetch(input addr_t addr, output word_t data, output int unsigned lat);
        @(negedge clk);
        shuffle_latency();
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        do @(negedge clk); while (!fetch_ready);
        @(posedge clk);
        fetch_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            check_flag("fetch_ready", fetch_ready, 1'b0);
        end while (!resp_valid);
        data = resp_data;
    endtask

    task automatic fetch_check(addr_t addr, int unsigned exp_ars);
        word_t       data;
        int unsigned lat;
        int unsigned ars_before;
        ars_before = ar_count;
        do_fetch(addr, data, lat);
        check_word("resp_data", data, expected_word(addr));
        check_count("AR handshakes", ar_count - ars_before, exp_ars);
        if (exp_ars == 0) check_count("hit latency", lat, 2);
    endtask

    task automatic pulse_fence();
        @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
    endtask

    task automatic test_first_miss();
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("fetch_ready", fetch_ready, 1'b1);
        ar_addrs.delete();
        fetch_check(32'h0000_0128, 4);
        foreach (ar_addrs[i]) begin
            check_addr("araddr", ar_addrs[i], 32'h0000_0120 + addr_t'(4 * i));
        end
    endtask

    task automatic test_line_hits();
        for (int unsigned i = 0; i < 4; i++) begin
            fetch_check(32'h0000_0120 + addr_t'(4 * i), 0);
        end
    endtask

    task automatic test_eviction();
        addr_t a;
        addr_t b;
        a = 32'h0000_0050;  // index 5, tag 0
        b = 32'h0000_0350;  // index 5, tag 3
        for (int unsigned i = 0; i < 3; i++) begin
            fetch_check(a + addr_t'(4 * i), 4);
            fetch_check(b + addr_t'(4 * (i + 1)), 4);
        end
    endtask

    task automatic test_fence_refetch();
        fetch_check(32'h0000_0128, 0);  // still resident
        pulse_fence();
        write_mem(32'h0000_0128, ~expected_word(32'h0000_0128));
        fetch_check(32'h0000_0128, 4);
    endtask

    task automatic test_fence_in_refill();
        addr_t       addr;
        word_t       data;
        word_t       old_word;
        int unsigned lat;
        int unsigned ars_before;
        addr       = 32'h0000_0364;
        old_word   = expected_word(addr);
        ars_before = ar_count;
        fork
            do_fetch(addr, data, lat);
            begin
                do @(negedge clk); while (!(arvalid && arready));
                pulse_fence();
            end
        join
        check_word("resp_data", data, old_word);
        check_count("AR handshakes", ar_count - ars_before, 4);
        write_mem(addr, old_word ^ 32'h5a5a_5a5a);
        fetch_check(addr, 4);  // line was never stored
    endtask

    task automatic test_random();
        logic [`ICACHE_LINES-1:0] sh_valid;
        tag_t                     sh_tag [`ICACHE_LINES];
        addr_t                    addr;
        index_t                   idx;
        tag_t                     tag;
        word_t                    data;
        int unsigned              lat;
        int unsigned              misses;
        int unsigned              ars_before;
        pulse_fence();
        sh_valid   = '0;
        misses     = 0;
        ars_before = ar_count;
        for (int unsigned i = 0; i < RAND_FETCHES; i++) begin
            addr = addr_t'($urandom_range(MEM_WORDS - 1, 0)) << 2;
            idx  = addr[7:4];
            tag  = addr[31:8];
            if (!sh_valid[idx] || sh_tag[idx] != tag) begin
                misses++;
                sh_valid[idx] = 1'b1;
                sh_tag[idx]   = tag;
            end
            do_fetch(addr, data, lat);
            check_word("resp_data", data, expected_word(addr));
        end
        check_count("AR handshakes", ar_count - ars_before, 4 * misses);
    endtask

    initial begin
        void'($urandom(32'h2309_c18d));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        fence_i     = 1'b0;
        for (int unsigned i = 0; i < MEM_WORDS; i++) begin
            write_mem(addr_t'(i * 4), $urandom());
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_first_miss();
        test_line_hits();
        test_eviction();
        test_fence_refetch();
        test_fence_in_refill();
        test_random();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verilog/icache_ctrl.sv
module icache_ctrl (
    input  logic               clk,
    input  logic               rst,

    input  logic               fetch_valid,
    input  icache_pkg::addr_t  fetch_addr,
    output logic               fetch_ready,
    output logic               resp_valid,
    output icache_pkg::word_t  resp_data,
    input  logic               fence_i,

    output icache_pkg::index_t lookup_index,
    output icache_pkg::tag_t   lookup_tag,
    input  logic               hit,
    input  icache_pkg::line_t  rd_line,
    output logic               fill_en,
    output icache_pkg::index_t fill_index,
    output icache_pkg::tag_t   fill_tag,
    output logic               flush,

    output logic               refill_start,
    output icache_pkg::addr_t  refill_addr,
    input  logic               refill_done,
    input  icache_pkg::line_t  refill_line
);
    import icache_pkg::*;

    ctrl_state_t state;
    addr_t       req_addr;
    tag_t        req_tag;
    index_t      req_index;
    woff_t       req_woff;
    logic        fence_seen;  // fence.i arrived while the line was in flight

    function automatic word_t pick_word(line_t line, woff_t woff);
        return line[woff*$bits(word_t) +: $bits(word_t)];
    endfunction

    assign req_tag   = req_addr[$bits(addr_t)-1 -: TAG_W];
    assign req_index = req_addr[OFF_W +: IDX_W];
    assign req_woff  = req_addr[BOFF_W +: WOFF_W];

    assign fetch_ready  = (state == IDLE);
    assign lookup_index = req_index;
    assign lookup_tag   = req_tag;

    assign refill_start = (state == LOOKUP) && !hit;
    assign refill_addr  = {req_addr[$bits(addr_t)-1:OFF_W], {OFF_W{1'b0}}};

    // Store gives flush priority over fill
    assign flush      = fence_i;
    assign fill_en    = (state == REFILL) && refill_done && !fence_seen;
    assign fill_index = req_index;
    assign fill_tag   = req_tag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            fence_seen <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (fetch_valid) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) begin
                        state      <= RESP;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (fence_i) fence_seen <= 1'b1;
                    if (refill_done) begin
                        state      <= RESP;
                        resp_valid <= 1'b1;
                        fence_seen <= 1'b0;
                    end
                end
                RESP: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) req_addr <= fetch_addr;
        if (state == LOOKUP && hit) begin
            resp_data <= pick_word(rd_line, req_woff);
        end else if (state == REFILL && refill_done) begin
            resp_data <= pick_word(refill_line, req_woff);  // answered even after a fence
        end
    end

    // Refill master only finishes a refill that was started
    a_done_in_refill: assert property (
        @(posedge clk) disable iff (rst)
        refill_done |-> (state == REFILL)
    ) else $error("refill_done outside REFILL");

endmodule

//--- verilog/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // Address split: tag | index | word offset | byte offset
    localparam int unsigned BOFF_W     = $clog2(`ICACHE_AXI_DW / 8);
    localparam int unsigned OFF_W      = $clog2(`ICACHE_LINE_BYTES);
    localparam int unsigned IDX_W      = $clog2(`ICACHE_LINES);
    localparam int unsigned TAG_W      = `ICACHE_ADDR_W - IDX_W - OFF_W;
    localparam int unsigned LINE_WORDS = `ICACHE_LINE_BYTES * 8 / `ICACHE_AXI_DW;
    localparam int unsigned WOFF_W     = $clog2(LINE_WORDS);

    typedef logic [`ICACHE_ADDR_W-1:0]       addr_t;
    typedef logic [`ICACHE_AXI_DW-1:0]       word_t;
    typedef logic [TAG_W-1:0]                tag_t;
    typedef logic [IDX_W-1:0]                index_t;
    typedef logic [WOFF_W-1:0]               woff_t;
    typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;  // word 0 in low bits

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESP
    } ctrl_state_t;

endpackage

//--- verilog/icache_refill_axi.sv
module icache_refill_axi (
    input  logic              clk,
    input  logic              rst,

    input  logic              refill_start,
    input  icache_pkg::addr_t refill_addr,
    output logic              refill_done,
    output icache_pkg::line_t refill_line,

    // AXI4-Lite read channels
    output icache_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  icache_pkg::word_t rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready
);
    import icache_pkg::*;

    logic                           busy;
    woff_t                          cnt;        // word being fetched
    logic [$bits(addr_t)-OFF_W-1:0] line_base;

    logic start;
    logic ar_hs;
    logic r_hs;
    logic last_beat;

    assign start     = refill_start && !busy;
    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign last_beat = (cnt == woff_t'(LINE_WORDS - 1));

    // cnt only moves while no AR is pending, so araddr holds until arready
    assign araddr = {line_base, cnt, {BOFF_W{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            cnt         <= '0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                cnt     <= '0;
                arvalid <= 1'b1;
            end
            if (ar_hs) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (r_hs) begin
                rready <= 1'b0;
                if (last_beat) begin
                    busy        <= 1'b0;
                    refill_done <= 1'b1;
                end else begin
                    cnt     <= cnt + 1'b1;
                    arvalid <= 1'b1;  // next word, one request at a time
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) line_base <= refill_addr[$bits(addr_t)-1:OFF_W];
        if (r_hs) refill_line[cnt*$bits(word_t) +: $bits(word_t)] <= rdata;
    end

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr))
    ) else $error("AR request changed before arready");

    // Error responses are not handled, memory is expected to answer OKAY
    a_rresp_okay: assert property (
        @(posedge clk) disable iff (rst)
        r_hs |-> (rresp == 2'b00)
    ) else $error("read response %0h on refill", rresp);

endmodule

//--- verilog/icache_store.sv
`include "icache_defines.svh"

module icache_store (
    input  logic               clk,
    input  logic               rst,

    input  icache_pkg::index_t lookup_index,
    input  icache_pkg::tag_t   lookup_tag,
    output logic               hit,
    output icache_pkg::line_t  rd_line,

    input  logic               fill_en,
    input  icache_pkg::index_t fill_index,
    input  icache_pkg::tag_t   fill_tag,
    input  icache_pkg::line_t  fill_line,
    input  logic               flush
);
    import icache_pkg::*;

    tag_t                     tag_array  [`ICACHE_LINES];
    line_t                    data_array [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_array;

    // Lookup straight from the arrays, index and tag come in registered
    assign hit     = valid_array[lookup_index] && (tag_array[lookup_index] == lookup_tag);
    assign rd_line = data_array[lookup_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_array <= '0;
        end else if (flush) begin
            valid_array <= '0;  // fence.i drops all lines
        end else if (fill_en) begin
            valid_array[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_array[fill_index]  <= fill_tag;
            data_array[fill_index] <= fill_line;
        end
    end

    // Refills only target a line that missed
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (rst)
        fill_en |-> !(valid_array[fill_index] && (tag_array[fill_index] == fill_tag))
    ) else $error("fill of line %0d that already holds its tag", fill_index);

endmodule

//--- verilog/icache_top.sv
module icache_top (
    input  logic              clk,
    input  logic              rst,

    // Fetch port from the core
    input  logic              fetch_valid,
    input  icache_pkg::addr_t fetch_addr,
    output logic              fetch_ready,
    output logic              resp_valid,
    output icache_pkg::word_t resp_data,
    input  logic              fence_i,

    // AXI4-Lite read side to instruction memory
    output icache_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  icache_pkg::word_t rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready
);
    import icache_pkg::*;

    index_t lookup_index;
    tag_t   lookup_tag;
    logic   hit;
    line_t  rd_line;
    logic   fill_en;
    index_t fill_index;
    tag_t   fill_tag;
    logic   flush;
    logic   refill_start;
    addr_t  refill_addr;
    logic   refill_done;
    line_t  refill_line;   // also the fill data for the store

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_ready  (fetch_ready),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .fence_i      (fence_i),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .rd_line      (rd_line),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .flush        (flush),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line)
    );

    icache_store store_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .rd_line      (rd_line),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (refill_line),
        .flush        (flush)
    );

    icache_refill_axi refill_i (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready)
    );

endmodule
